// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= wave_channel_tb
FLIST     ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := design/wave_defines.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== design/wave_bus_pkg.sv ====
`include "wave_defines.svh"

package wave_bus_pkg;

	// master side of a classic cycle
	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [`WAVE_ADR_W-1:0] adr;
		logic [7:0]             dat;
	} wb_req_t;

	// slave side
	typedef struct packed {
		logic       ack;
		logic [7:0] dat; // valid with ack
	} wb_rsp_t;

endpackage

// ==== design/wave_chan_pkg.sv ====
`include "wave_defines.svh"

package wave_chan_pkg;

	// channel setup as held by the register block
	typedef struct packed {
		logic                    dac_on;
		logic [1:0]              volume;
		logic [`WAVE_FREQ_W-1:0] freq;
	} wave_cfg_t;

	// One stored byte. The cpu sees the raw byte and playback
	// picks one of the two nibbles.
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [3:0] hi; // even sample
			logic [3:0] lo; // odd sample
		} nib;
	} wave_byte_u;

	// index into 32 samples
	typedef logic [4:0] wave_pos_t;

endpackage

// ==== design/wave_channel.sv ====
`timescale 1ns/10ps

module wave_channel (
	input  logic                  amuk_4mhz,
	input  logic                  arst_n,
	input  wave_bus_pkg::wb_req_t wb_req,
	output wave_bus_pkg::wb_rsp_t wb_rsp,
	output logic [3:0]            dac_out,
	output logic                  ch_active
);
	import wave_chan_pkg::*;

	wave_cfg_t  cfg;
	wave_pos_t  pos;
	logic       trigger;
	logic       ram_we;
	logic [3:0] ram_adr;
	logic [7:0] ram_wdat;
	logic [7:0] ram_rdat;
	logic [3:0] sample;

	wave_regs u_regs (
		.amuk_4mhz (amuk_4mhz),
		.arst_n    (arst_n),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.cfg       (cfg),
		.trigger   (trigger),
		.ch_active (ch_active),
		.ram_we    (ram_we),
		.ram_adr   (ram_adr),
		.ram_wdat  (ram_wdat),
		.ram_rdat  (ram_rdat)
	);

	wave_ram u_ram (
		.amuk_4mhz (amuk_4mhz),
		.arst_n    (arst_n),
		.cpu_we    (ram_we),
		.cpu_adr   (ram_adr),
		.cpu_wdat  (ram_wdat),
		.cpu_rdat  (ram_rdat),
		.pos       (pos),
		.sample    (sample)
	);

	wave_timer u_timer (
		.amuk_4mhz (amuk_4mhz),
		.arst_n    (arst_n),
		.cfg       (cfg),
		.trigger   (trigger),
		.pos       (pos),
		.ch_active (ch_active)
	);

	wave_output u_output (
		.amuk_4mhz (amuk_4mhz),
		.arst_n    (arst_n),
		.sample    (sample),
		.volume    (cfg.volume),
		.ch_active (ch_active),
		.dac_out   (dac_out)
	);

endmodule

// ==== design/wave_defines.svh ====
`ifndef WAVE_DEFINES_SVH
`define WAVE_DEFINES_SVH

// sample store
`define WAVE_RAM_BYTES 16 // 32 samples, two per byte

// frequency value from NR33 and NR34
`define WAVE_FREQ_W 11

// wishbone address width, registers plus ram window
`define WAVE_ADR_W 5

// channel registers
`define WAVE_ADR_NR30 5'd0 // dac enable
`define WAVE_ADR_NR31 5'd1 // length, not implemented
`define WAVE_ADR_NR32 5'd2 // volume code
`define WAVE_ADR_NR33 5'd3 // freq low byte
`define WAVE_ADR_NR34 5'd4 // trigger, freq high bits

// wave ram window, 16 to 31
`define WAVE_ADR_RAM 5'd16

`endif

// ==== design/wave_output.sv ====
`timescale 1ns/10ps

module wave_output (
	input  logic       amuk_4mhz,
	input  logic       arst_n,
	input  logic [3:0] sample,
	input  logic [1:0] volume,
	input  logic       ch_active,
	output logic [3:0] dac_out
);
	logic [3:0] scaled;
	logic [3:0] dac_q;

	always_comb begin
		case (volume)
			2'd0:    scaled = '0; // mute
			2'd1:    scaled = sample;
			2'd2:    scaled = sample >> 1;
			default: scaled = sample >> 2;
		endcase
	end

	always_ff @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			dac_q <= '0;
		end else begin
			dac_q <= ch_active ? scaled : 4'd0;
		end
	end

	assign dac_out = dac_q;

endmodule

// ==== design/wave_ram.sv ====
`timescale 1ns/10ps

`include "wave_defines.svh"

module wave_ram (
	input  logic                     amuk_4mhz,
	input  logic                     arst_n,
	input  logic                     cpu_we,
	input  logic [3:0]               cpu_adr,
	input  logic [7:0]               cpu_wdat,
	output logic [7:0]               cpu_rdat,
	input  wave_chan_pkg::wave_pos_t pos,
	output logic [3:0]               sample
);
	import wave_chan_pkg::*;

	wave_byte_u mem [`WAVE_RAM_BYTES];
	wave_byte_u play_byte;
	logic [3:0] sample_q;

	always_ff @(posedge amuk_4mhz) begin
		if (cpu_we) begin
			mem[cpu_adr].raw <= cpu_wdat;
		end
	end

	assign cpu_rdat = mem[cpu_adr].raw; // registered in wave_regs

	// two samples per byte
	assign play_byte = mem[pos[4:1]];

	always_ff @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			sample_q <= '0;
		end else begin
			sample_q <= pos[0] ? play_byte.nib.lo : play_byte.nib.hi; // hi nibble first
		end
	end

	assign sample = sample_q;

	// pos only moves while playing, so a cpu write never lands on a step
	a_no_write_on_step: assert property (@(posedge amuk_4mhz) disable iff (!arst_n)
		cpu_we |=> $stable(pos));

endmodule

// ==== design/wave_regs.sv ====
`timescale 1ns/10ps

`include "wave_defines.svh"

module wave_regs (
	input  logic                     amuk_4mhz,
	input  logic                     arst_n,
	input  wave_bus_pkg::wb_req_t    wb_req,
	output wave_bus_pkg::wb_rsp_t    wb_rsp,
	output wave_chan_pkg::wave_cfg_t cfg,
	output logic                     trigger,
	input  logic                     ch_active,
	output logic                     ram_we,
	output logic [3:0]               ram_adr,
	output logic [7:0]               ram_wdat,
	input  logic [7:0]               ram_rdat
);
	import wave_chan_pkg::*;

	wave_cfg_t  cfg_q;
	logic       ack_q;
	logic       done_q; // set until stb drops
	logic       trig_q;
	logic       accept;
	logic       is_ram;
	logic [7:0] rd_mux;
	logic [7:0] rdat_q;

	assign accept = wb_req.cyc && wb_req.stb && !done_q;
	assign is_ram = wb_req.adr >= `WAVE_ADR_RAM;

	assign ram_we   = accept && wb_req.we && is_ram && !ch_active; // ram locked while playing
	assign ram_adr  = wb_req.adr[3:0];
	assign ram_wdat = wb_req.dat;

	always_comb begin
		case (wb_req.adr)
			`WAVE_ADR_NR30: rd_mux = {cfg_q.dac_on, 7'h7f};
			`WAVE_ADR_NR31: rd_mux = 8'hff;
			`WAVE_ADR_NR32: rd_mux = {1'b1, cfg_q.volume, 5'h1f};
			`WAVE_ADR_NR33: rd_mux = cfg_q.freq[7:0];
			`WAVE_ADR_NR34: rd_mux = {5'h1f, cfg_q.freq[`WAVE_FREQ_W-1:8]};
			default:        rd_mux = (is_ram && !ch_active) ? ram_rdat : 8'hff;
		endcase
	end

	always_ff @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			cfg_q  <= '0;
			ack_q  <= 1'b0;
			done_q <= 1'b0;
			trig_q <= 1'b0;
		end else begin
			ack_q  <= accept;
			done_q <= accept || (done_q && wb_req.stb);
			trig_q <= accept && wb_req.we && (wb_req.adr == `WAVE_ADR_NR34) && wb_req.dat[7];
			if (accept && wb_req.we) begin
				case (wb_req.adr)
					`WAVE_ADR_NR30: cfg_q.dac_on <= wb_req.dat[7];
					`WAVE_ADR_NR32: cfg_q.volume <= wb_req.dat[6:5];
					`WAVE_ADR_NR33: cfg_q.freq[7:0] <= wb_req.dat;
					`WAVE_ADR_NR34: cfg_q.freq[`WAVE_FREQ_W-1:8] <= wb_req.dat[`WAVE_FREQ_W-9:0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge amuk_4mhz) begin
		if (accept) begin
			rdat_q <= rd_mux; // presented with ack
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rdat_q;
	assign cfg        = cfg_q;
	assign trigger    = trig_q;

	// one ack per request, the master must drop stb in between
	a_ack_single: assert property (@(posedge amuk_4mhz) disable iff (!arst_n)
		wb_rsp.ack |=> !wb_rsp.ack);

endmodule

// ==== design/wave_timer.sv ====
`timescale 1ns/10ps

`include "wave_defines.svh"

module wave_timer (
	input  logic                     amuk_4mhz,
	input  logic                     arst_n,
	input  wave_chan_pkg::wave_cfg_t cfg,
	input  logic                     trigger,
	output wave_chan_pkg::wave_pos_t pos,
	output logic                     ch_active
);
	import wave_chan_pkg::*;

	logic [`WAVE_FREQ_W-1:0] cnt_q;
	logic [`WAVE_FREQ_W-1:0] period;
	wave_pos_t               pos_q;
	logic                    active_q;
	logic                    step;

	// 2048 - freq, freq 0 wraps round to a full 2048 count
	assign period = ~cfg.freq + 1'b1;

	assign step = active_q && (cnt_q == `WAVE_FREQ_W'd1);

	always_ff @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			cnt_q    <= '0;
			pos_q    <= '0;
			active_q <= 1'b0;
		end else if (trigger) begin
			active_q <= cfg.dac_on;
			pos_q    <= '0;
			cnt_q    <= period;
		end else begin
			if (!cfg.dac_on) begin
				active_q <= 1'b0; // dac off stops the channel
			end
			if (step) begin
				cnt_q <= period;
				pos_q <= pos_q + 1'b1; // wraps at 32
			end else if (active_q) begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

	assign pos       = pos_q;
	assign ch_active = active_q;

	// playback walks the table in order, restart only from trigger
	a_pos_order: assert property (@(posedge amuk_4mhz) disable iff (!arst_n)
		!$stable(pos_q) |->
			(pos_q == wave_pos_t'($past(pos_q) + 1'b1)) ||
			($past(trigger) && (pos_q == '0)));

endmodule

// ==== tb.f ====
+incdir+design
design/wave_bus_pkg.sv
design/wave_chan_pkg.sv
design/wave_regs.sv
design/wave_ram.sv
design/wave_timer.sv
design/wave_output.sv
design/wave_channel.sv
testbench/wave_channel_tb.sv

// ==== testbench/wave_channel_tb.sv ====
`timescale 1ns/10ps

`include "wave_defines.svh"

module wave_channel_tb;
	import wave_bus_pkg::*;

	localparam int PERIOD_CYC  = 8; // freq 2040
	localparam int CYCLE_LIMIT = 20000; // about 6 full table passes plus bus traffic, with margin

	logic       amuk_4mhz = 1'b0;
	logic       arst_n;
	wb_req_t    wb_req;
	wb_rsp_t    wb_rsp;
	logic [3:0] dac_out;
	logic       ch_active;

	integer     seed = 71126;
	int         cycles = 0;
	logic [3:0] nib [32];

	// reference model state
	logic                    m_dac_on;
	logic [1:0]              m_vol;
	logic [`WAVE_FREQ_W-1:0] m_freq;
	logic [7:0]              m_ram [`WAVE_RAM_BYTES];
	logic                    m_active;
	logic [4:0]              m_pos;
	logic [`WAVE_FREQ_W-1:0] m_cnt;
	logic [3:0]              m_sample;
	logic [3:0]              m_dac;
	logic                    n_dac_on;
	logic [1:0]              n_vol;
	logic [`WAVE_FREQ_W-1:0] n_freq;
	logic                    n_trig;
	logic [7:0]              cur;

	wave_channel u_wave_channel (
		.amuk_4mhz (amuk_4mhz),
		.arst_n    (arst_n),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.dac_out   (dac_out),
		.ch_active (ch_active)
	);

	always #2 amuk_4mhz = ~amuk_4mhz;

	task automatic stop_run();
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic fail_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		$display("[FAIL] %s got %h expected %h", name, got, exp);
		stop_run();
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got == exp) else fail_value(name, got, exp);
	endtask

	function automatic logic [`WAVE_FREQ_W-1:0] period_of(input logic [`WAVE_FREQ_W-1:0] f);
		period_of = `WAVE_FREQ_W'(12'd2048 - {1'b0, f});
	endfunction

	function automatic logic [3:0] scale(input logic [3:0] s, input logic [1:0] vol);
		case (vol)
			2'd0:    scale = 4'd0;
			2'd1:    scale = s;
			2'd2:    scale = s >> 1;
			default: scale = s >> 2;
		endcase
	endfunction

	function automatic logic [7:0] expect_read(input logic [4:0] adr);
		if (adr >= `WAVE_ADR_RAM)
			expect_read = m_active ? 8'hff : m_ram[adr[3:0]]; // locked while playing
		else if (adr == `WAVE_ADR_NR30)
			expect_read = {m_dac_on, 7'h7f};
		else if (adr == `WAVE_ADR_NR32)
			expect_read = {1'b1, m_vol, 5'h1f};
		else if (adr == `WAVE_ADR_NR33)
			expect_read = m_freq[7:0];
		else if (adr == `WAVE_ADR_NR34)
			expect_read = {5'h1f, m_freq[`WAVE_FREQ_W-1:8]};
		else
			expect_read = 8'hff;
	endfunction

	task automatic bus_cycle(input logic we, input logic [4:0] adr, input logic [7:0] wdat,
			output logic [7:0] rdat);
		wb_req_t req;
		int      waited;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we  = we;
		req.adr = adr;
		req.dat = wdat;
		wb_req <= req;
		waited = 0;
		do begin
			@(posedge amuk_4mhz);
			waited++;
		end while (!wb_rsp.ack);
		check_byte("wb_rsp.ack latency", 8'(waited), 8'd2); // sampled on one edge, ack by the next
		rdat = wb_rsp.dat;
		wb_req <= '0;
		@(posedge amuk_4mhz); // let stb drop before the next request
	endtask

	task automatic bus_write(input logic [4:0] adr, input logic [7:0] dat);
		logic [7:0] unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic read_check(input logic [4:0] adr);
		logic [7:0] exp;
		logic [7:0] got;
		exp = expect_read(adr);
		bus_cycle(1'b0, adr, 8'h00, got);
		check_byte($sformatf("wb_rsp.dat @%02h", adr), got, exp);
	endtask

	// model follows the register writes seen at ack
	always @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			m_dac_on <= 1'b0;
			m_vol    <= '0;
			m_freq   <= '0;
			m_active <= 1'b0;
			m_pos    <= '0;
			m_cnt    <= '0;
			m_sample <= '0;
			m_dac    <= '0;
		end else begin
			n_dac_on = m_dac_on;
			n_vol    = m_vol;
			n_freq   = m_freq;
			n_trig   = 1'b0;
			if (wb_rsp.ack && wb_req.we) begin
				case (wb_req.adr)
					`WAVE_ADR_NR30: n_dac_on = wb_req.dat[7];
					`WAVE_ADR_NR32: n_vol = wb_req.dat[6:5];
					`WAVE_ADR_NR33: n_freq[7:0] = wb_req.dat;
					`WAVE_ADR_NR34: begin
						n_freq[`WAVE_FREQ_W-1:8] = wb_req.dat[2:0];
						n_trig = wb_req.dat[7];
					end
					default: begin
						if (wb_req.adr >= `WAVE_ADR_RAM && !m_active)
							m_ram[wb_req.adr[3:0]] <= wb_req.dat;
					end
				endcase
			end
			m_dac_on <= n_dac_on;
			m_vol    <= n_vol;
			m_freq   <= n_freq;
			m_dac    <= m_active ? scale(m_sample, n_vol) : 4'd0;
			cur = m_ram[m_pos[4:1]];
			m_sample <= m_pos[0] ? cur[3:0] : cur[7:4]; // hi nibble on even pos
			if (n_trig) begin
				m_active <= n_dac_on;
				m_pos    <= '0;
				m_cnt    <= period_of(n_freq);
			end else begin
				if (!n_dac_on)
					m_active <= 1'b0;
				if (m_active && m_cnt == `WAVE_FREQ_W'd1) begin
					m_cnt <= period_of(n_freq);
					m_pos <= m_pos + 5'd1;
				end else begin
					m_cnt <= m_cnt - `WAVE_FREQ_W'd1;
				end
			end
		end
	end

	a_dac_match: assert property (@(posedge amuk_4mhz) disable iff (!arst_n)
		dac_out == m_dac)
		else fail_value("dac_out", {4'h0, $sampled(dac_out)}, {4'h0, $sampled(m_dac)});

	a_active_match: assert property (@(posedge amuk_4mhz) disable iff (!arst_n)
		ch_active == m_active)
		else fail_value("ch_active", {7'h0, $sampled(ch_active)}, {7'h0, $sampled(m_active)});

	always @(posedge amuk_4mhz) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
			stop_run();
		end
	end

	initial begin
		arst_n <= 1'b0;
		wb_req <= '0;
		// neighbouring nibbles differ, the wrap included
		for (int i = 0; i < 32; i++) begin
			nib[i] = 4'($random(seed));
			while ((i > 0 && nib[i] == nib[i-1]) || (i == 31 && nib[i] == nib[0]))
				nib[i] = nib[i] + 4'd1;
		end
		repeat (8) @(posedge amuk_4mhz);
		arst_n <= 1'b1;
		@(posedge amuk_4mhz);

		bus_write(`WAVE_ADR_NR30, 8'h80);
		bus_write(`WAVE_ADR_NR32, 8'h40);
		bus_write(`WAVE_ADR_NR33, 8'hf8);
		bus_write(`WAVE_ADR_NR34, 8'h07); // freq 2040, no trigger
		for (int a = 0; a < 5; a++)
			read_check(5'(a));

		for (int b = 0; b < `WAVE_RAM_BYTES; b++)
			bus_write(`WAVE_ADR_RAM + 5'(b), {nib[2*b], nib[2*b+1]});
		for (int b = 0; b < `WAVE_RAM_BYTES; b++)
			read_check(`WAVE_ADR_RAM + 5'(b));

		bus_write(`WAVE_ADR_NR32, 8'h20);
		bus_write(`WAVE_ADR_NR34, 8'h87);
		while (!ch_active)
			@(posedge amuk_4mhz);
		read_check(`WAVE_ADR_RAM);
		bus_write(`WAVE_ADR_RAM + 5'd3, ~{nib[6], nib[7]}); // must be dropped
		bus_write(`WAVE_ADR_NR30, 8'h00);
		while (ch_active)
			@(posedge amuk_4mhz);
		for (int b = 0; b < `WAVE_RAM_BYTES; b++)
			read_check(`WAVE_ADR_RAM + 5'(b));

		bus_write(`WAVE_ADR_NR30, 8'h80);
		bus_write(`WAVE_ADR_NR34, 8'h87);
		repeat (PERIOD_CYC * 40) @(posedge amuk_4mhz); // past one wrap

		for (int v = 2; v < 6; v++) begin
			bus_write(`WAVE_ADR_NR32, {1'b0, 2'(v), 5'h00}); // codes 2, 3, 0, 1
			repeat (PERIOD_CYC * 34) @(posedge amuk_4mhz);
		end

		bus_write(`WAVE_ADR_NR30, 8'h00);
		repeat (2) @(posedge amuk_4mhz);
		check_byte("ch_active", {7'h0, ch_active}, 8'h00);
		check_byte("dac_out", {4'h0, dac_out}, 8'h00);

		$display("TESTS PASSED");
		$finish;
	end

endmodule
